//--- common/tipi_params.svh
`ifndef TIPI_PARAMS_SVH
`define TIPI_PARAMS_SVH

// dsr rom size in KiB, 4K is plenty for the real DSR
`define TIPI_DSR_ROM_SIZE_K 4

`define TIPI_DSR_ROM_DEPTH (`TIPI_DSR_ROM_SIZE_K * 1024)

// a[0:2] of the 0x4000 window
`define TIPI_DSR_WINDOW 3'b010

// a[0:12] of the mailbox block 0x5ff8..0x5fff
`define TIPI_REG_BASE 13'h0bff

// cru page, a[0:7]
`define TIPI_CRU_BASE 8'h12

`define TIPI_TD_RESET 8'hab

`endif

//--- common/tipi_bus_pkg.sv
`default_nettype none

package tipi_bus_pkg;

   // console side of the expansion bus, TI bit order
   typedef struct packed {
      logic [0:15] addr;
      logic [0:7]  data;
      logic        memen;
      logic        we;
      logic        cruclk;
   } host_bus_t;

   // wishbone request into the rom loader port
   typedef struct packed {
      logic [0:14] adr;
      logic [0:7]  dat;
      logic        we;
      logic        sel;
      logic        stb;
      logic        cyc;
   } wb_req_t;

   typedef struct packed {
      logic       dsr_en;
      logic       rpi_en;
      logic [1:0] bank;
   } cru_bits_t;

   // picked by a[13:14]
   typedef enum logic [1:0] {
      CRU_DSR_EN = 2'b00,
      CRU_RPI_EN = 2'b01,
      CRU_BANK0  = 2'b10,
      CRU_BANK1  = 2'b11
   } cru_bit_e;

endpackage

`default_nettype wire

//--- common/tipi_link_pkg.sv
`default_nettype none

package tipi_link_pkg;

   // raw pins from the pi
   typedef struct packed {
      logic r_clk;
      logic r_rt;
      logic r_le;
      logic r_dout;
      logic r_dc;
   } rpi_pins_t;

   // levels captured on the pi clock edge
   typedef struct packed {
      logic rt;
      logic le;
      logic dout;
      logic dc;
   } rpi_samp_t;

   typedef struct packed {
      logic [0:7] tc;
      logic [0:7] td;
      logic [0:7] rc;
      logic [0:7] rd;
   } mailbox_t;

   // a[13:15] inside the mailbox block, even addresses unused
   typedef enum logic [2:0] {
      MB_RC = 3'b001,
      MB_RD = 3'b011,
      MB_TC = 3'b101,
      MB_TD = 3'b111
   } mbox_reg_e;

endpackage

`default_nettype wire

//--- design/tipi_cru_bits.sv
`default_nettype none

`include "tipi_params.svh"

module tipi_cru_bits (
   input  wire                          clk,
   input  wire                          arst_n_i,
   input  wire                          enable_i,
   input  wire tipi_bus_pkg::host_bus_t bus_i,
   output logic                         cru_select_o,
   output logic                         cruin_o,
   output tipi_bus_pkg::cru_bits_t      bits_o
);

   tipi_bus_pkg::cru_bit_e bit_sel;

   assign bit_sel      = tipi_bus_pkg::cru_bit_e'(bus_i.addr[13:14]);
   assign cru_select_o = enable_i && (bus_i.addr[0:7] == `TIPI_CRU_BASE);

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         bits_o <= '0;
      end else if (!enable_i) begin
         bits_o <= '0;   // card pulled, forget everything
      end else if (bus_i.cruclk && cru_select_o) begin
         case (bit_sel)
            tipi_bus_pkg::CRU_DSR_EN: bits_o.dsr_en  <= bus_i.addr[15];
            tipi_bus_pkg::CRU_RPI_EN: bits_o.rpi_en  <= bus_i.addr[15];
            tipi_bus_pkg::CRU_BANK0:  bits_o.bank[0] <= bus_i.addr[15];
            tipi_bus_pkg::CRU_BANK1:  bits_o.bank[1] <= bus_i.addr[15];
            default: ;
         endcase
      end
   end

   // readback of the addressed bit
   always_comb begin
      case (bit_sel)
         tipi_bus_pkg::CRU_DSR_EN: cruin_o = bits_o.dsr_en;
         tipi_bus_pkg::CRU_RPI_EN: cruin_o = bits_o.rpi_en;
         tipi_bus_pkg::CRU_BANK0:  cruin_o = bits_o.bank[0];
         tipi_bus_pkg::CRU_BANK1:  cruin_o = bits_o.bank[1];
         default:                  cruin_o = 1'b0;
      endcase
   end

endmodule

`default_nettype wire

//--- design/tipi_host_decode.sv
`default_nettype none

`include "tipi_params.svh"

module tipi_host_decode (
   input  wire                          clk,
   input  wire                          arst_n_i,
   input  wire tipi_bus_pkg::host_bus_t bus_i,
   input  wire                          dsr_en_i,
   input  wire [1:0]                    bank_i,
   input  wire [0:7]                    rom_data_i,
   input  wire [0:7]                    rc_i,
   input  wire [0:7]                    rd_i,
   output logic [0:7]                   q_o,
   output logic                         q_select_o,
   output logic                         dsr_rd_o,
   output logic [0:14]                  rom_addr_o,
   output logic [0:7]                   tc_o,
   output logic [0:7]                   td_o
);

   tipi_link_pkg::mbox_reg_e reg_sel;
   logic                     in_regs;
   logic                     reg_wr;
   logic [0:7]               reg_data;

   assign q_select_o = dsr_en_i && (bus_i.addr[0:2] == `TIPI_DSR_WINDOW);
   assign dsr_rd_o   = q_select_o && bus_i.memen && !bus_i.we;
   assign in_regs    = (bus_i.addr[0:12] == `TIPI_REG_BASE);
   assign reg_wr     = q_select_o && bus_i.memen && bus_i.we && in_regs;
   assign reg_sel    = tipi_link_pkg::mbox_reg_e'(bus_i.addr[13:15]);

   // 8K per bank
   assign rom_addr_o = {bank_i, bus_i.addr[3:15]};

   always_ff @(posedge clk) begin
      if (dsr_rd_o) begin
         case (reg_sel)
            tipi_link_pkg::MB_RC: reg_data <= rc_i;
            tipi_link_pkg::MB_RD: reg_data <= rd_i;
            tipi_link_pkg::MB_TC: reg_data <= tc_o;
            tipi_link_pkg::MB_TD: reg_data <= td_o;
            default:              reg_data <= 8'h00;   // even addresses
         endcase
      end
   end

   // console side of the mailbox
   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         tc_o <= 8'h00;
         td_o <= `TIPI_TD_RESET;
      end else if (reg_wr) begin
         case (reg_sel)
            tipi_link_pkg::MB_TC: tc_o <= bus_i.data;
            tipi_link_pkg::MB_TD: td_o <= bus_i.data;
            default: ;   // rc/rd belong to the pi
         endcase
      end
   end

   assign q_o = in_regs ? reg_data : rom_data_i;

endmodule

`default_nettype wire

//--- dsr_rom/tipi_dsr_rom.sv
`default_nettype none

`include "tipi_params.svh"

module tipi_dsr_rom (
   input  wire                        clk,
   input  wire                        arst_n_i,
   input  wire                        dsr_rd_i,
   input  wire [0:14]                 rom_addr_i,
   input  wire tipi_bus_pkg::wb_req_t wb_i,
   output logic [0:7]                 rd_data_o,
   output logic                       wb_ack_o
);

   localparam int DEPTH = `TIPI_DSR_ROM_DEPTH;
   localparam int AW    = $clog2(DEPTH);

   logic [0:7]  mem [0:DEPTH-1];
   logic [0:14] rd_addr;
   logic [AW-1:0] rd_idx;
   logic        wb_req;
   logic        wb_rd;
   logic        wb_wr;

   assign wb_req = wb_i.cyc && wb_i.stb;
   assign wb_rd  = wb_req && !wb_i.we;
   // write lands in the ack cycle, out-of-range addresses are dropped
   assign wb_wr  = wb_req && wb_i.we && wb_ack_o && wb_i.sel &&
                   (wb_i.adr < 15'(DEPTH));

   // console wins the read port
   assign rd_addr = dsr_rd_i ? rom_addr_i : wb_i.adr;
   assign rd_idx  = rd_addr[15-AW:14];   // banks alias above the rom size

   always_ff @(posedge clk) begin
      if (dsr_rd_i || wb_rd) begin
         rd_data_o <= mem[rd_idx];
      end
      if (wb_wr) begin
         mem[wb_i.adr[15-AW:14]] <= wb_i.dat;
      end
   end

   // single cycle ack, reads stall while the console is reading
   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wb_ack_o <= 1'b0;
      end else if (!wb_req || wb_ack_o) begin
         wb_ack_o <= 1'b0;
      end else begin
         wb_ack_o <= wb_i.we || !dsr_rd_i;
      end
   end

endmodule

`default_nettype wire

//--- rpi_link/tipi_rpi_sync.sv
`default_nettype none

module tipi_rpi_sync (
   input  wire                           clk,
   input  wire                           arst_n_i,
   input  wire tipi_link_pkg::rpi_pins_t pins_i,
   output logic                          tick_o,
   output tipi_link_pkg::rpi_samp_t      samp_o
);

   // newest sample enters at the right
   logic [0:5] clk_hist;
   logic       rise;

   // low for three samples then high, filters glitches on r_clk
   assign rise = (clk_hist[0:3] == 4'b0001);

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         clk_hist <= '0;
         tick_o   <= 1'b0;
         samp_o   <= '0;
      end else begin
         clk_hist <= {clk_hist[1:5], pins_i.r_clk};
         tick_o   <= rise;
         if (rise) begin
            // pi data lines settled long before its clock edge got here
            samp_o.rt   <= pins_i.r_rt;
            samp_o.le   <= pins_i.r_le;
            samp_o.dout <= pins_i.r_dout;
            samp_o.dc   <= pins_i.r_dc;
         end
      end
   end

endmodule

`default_nettype wire

//--- rpi_link/tipi_rpi_shifter.sv
`default_nettype none

module tipi_rpi_shifter (
   input  wire                           clk,
   input  wire                           arst_n_i,
   input  wire                           tick_i,
   input  wire tipi_link_pkg::rpi_samp_t samp_i,
   input  wire [0:7]                     tc_i,
   input  wire [0:7]                     td_i,
   output logic [0:7]                    rc_o,
   output logic [0:7]                    rd_o,
   output logic                          r_din_o
);

   logic [0:7] shift_dout;   // pi -> console
   logic [0:7] shift_din;    // console -> pi
   logic       parity;
   logic       din_dly;
   logic       latch_tick;
   logic       shift_tick;

   assign latch_tick = tick_i && samp_i.le;
   assign shift_tick = tick_i && !samp_i.le;

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         shift_dout <= 8'h00;
         shift_din  <= 8'h00;
         parity     <= 1'b0;
         din_dly    <= 1'b0;
      end else if (latch_tick) begin
         shift_din <= samp_i.dc ? td_i : tc_i;
      end else if (shift_tick) begin
         parity     <= parity ^ shift_dout[0] ^ shift_dout[7];
         shift_dout <= {shift_dout[1:7], samp_i.dout};
         din_dly    <= shift_din[0];   // msb goes out first
         shift_din  <= {shift_din[1:7], ^shift_din};
      end
   end

   // rt low on a latch means the pi is handing over a byte
   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         rc_o <= 8'h00;
         rd_o <= 8'h00;
      end else if (latch_tick && !samp_i.rt) begin
         if (samp_i.dc) begin
            rd_o <= shift_dout;
         end else begin
            rc_o <= shift_dout;
         end
      end
   end

   // rt high: data to the pi, otherwise echo check for the pi
   assign r_din_o = samp_i.rt ? din_dly : (parity ^ shift_dout[7]);

endmodule

`default_nettype wire

//--- design/tipi_card.sv
`default_nettype none

module tipi_card (
   input  wire                         clk,
   input  wire                         arst_n_i,
   input  wire                         enable_i,
   input  wire tipi_bus_pkg::host_bus_t bus_i,
   input  wire tipi_bus_pkg::wb_req_t  wb_i,
   input  wire tipi_link_pkg::rpi_pins_t pi_i,
   output logic [0:7]                  q_o,
   output logic                        q_select_o,
   output logic                        cruin_o,
   output logic                        cru_select_o,
   output logic                        led_o,
   output logic [0:7]                  wb_dat_o,
   output logic                        wb_ack_o,
   output logic                        r_reset_o,
   output logic                        r_din_o
);

   tipi_bus_pkg::cru_bits_t  cru_bits;
   tipi_link_pkg::mailbox_t  mbox;
   tipi_link_pkg::rpi_samp_t samp;
   logic                     tick;
   logic                     dsr_rd;
   logic [0:14]              rom_addr;
   logic [0:7]               rom_data;

   tipi_cru_bits u_cru_bits (
      .clk          (clk),
      .arst_n_i     (arst_n_i),
      .enable_i     (enable_i),
      .bus_i        (bus_i),
      .cru_select_o (cru_select_o),
      .cruin_o      (cruin_o),
      .bits_o       (cru_bits)
   );

   tipi_host_decode u_host_decode (
      .clk        (clk),
      .arst_n_i   (arst_n_i),
      .bus_i      (bus_i),
      .dsr_en_i   (cru_bits.dsr_en),
      .bank_i     (cru_bits.bank),
      .rom_data_i (rom_data),
      .rc_i       (mbox.rc),
      .rd_i       (mbox.rd),
      .q_o        (q_o),
      .q_select_o (q_select_o),
      .dsr_rd_o   (dsr_rd),
      .rom_addr_o (rom_addr),
      .tc_o       (mbox.tc),
      .td_o       (mbox.td)
   );

   tipi_dsr_rom u_dsr_rom (
      .clk        (clk),
      .arst_n_i   (arst_n_i),
      .dsr_rd_i   (dsr_rd),
      .rom_addr_i (rom_addr),
      .wb_i       (wb_i),
      .rd_data_o  (rom_data),
      .wb_ack_o   (wb_ack_o)
   );

   tipi_rpi_sync u_rpi_sync (
      .clk      (clk),
      .arst_n_i (arst_n_i),
      .pins_i   (pi_i),
      .tick_o   (tick),
      .samp_o   (samp)
   );

   tipi_rpi_shifter u_rpi_shifter (
      .clk      (clk),
      .arst_n_i (arst_n_i),
      .tick_i   (tick),
      .samp_i   (samp),
      .tc_i     (mbox.tc),
      .td_i     (mbox.td),
      .rc_o     (mbox.rc),
      .rd_o     (mbox.rd),
      .r_din_o  (r_din_o)
   );

   assign wb_dat_o  = rom_data;   // wishbone reads share the rom port
   assign led_o     = cru_bits.dsr_en;
   assign r_reset_o = ~cru_bits.rpi_en;   // pi held in reset until enabled

endmodule

`default_nettype wire

//--- dv/tipi_card_chk.sv
`default_nettype none

module tipi_card_chk (
   input wire                          clk,
   input wire                          arst_n_i,
   input wire                          enable_i,
   input wire tipi_bus_pkg::host_bus_t bus_i,
   input wire tipi_bus_pkg::wb_req_t   wb_i,
   input wire                          wb_ack_i,
   input wire                          q_select_i,
   input wire                          cru_select_i,
   input wire                          led_i,
   input wire                          r_reset_i
);

   int unsigned fail_cnt = 0;   // failed assertions so far

   tipi_bus_pkg::cru_bit_e cru_idx;
   logic                   cru_wr;

   assign cru_idx = tipi_bus_pkg::cru_bit_e'(bus_i.addr[13:14]);
   assign cru_wr  = bus_i.cruclk && cru_select_i;

   ack_single: assert property (@(posedge clk) disable iff (!arst_n_i)
      wb_ack_i |=> !wb_ack_i)
      else begin
         fail_cnt++;
         $error("wishbone ack stayed high for two cycles");
      end

   // ack only answers a request from the cycle before
   ack_after_req: assert property (@(posedge clk) disable iff (!arst_n_i)
      $rose(wb_ack_i) |-> $past(wb_i.cyc && wb_i.stb))
      else begin
         fail_cnt++;
         $error("wishbone ack without a request");
      end

   qsel_needs_dsr: assert property (@(posedge clk) disable iff (!arst_n_i)
      !led_i |-> !q_select_i)
      else begin
         fail_cnt++;
         $error("q_select_o high while dsr is disabled");
      end

   enable_clears: assert property (@(posedge clk) disable iff (!arst_n_i)
      !enable_i |=> (!led_i && r_reset_i))
      else begin
         fail_cnt++;
         $error("control bits kept after enable dropped");
      end

   dsr_bit_write: assert property (@(posedge clk) disable iff (!arst_n_i)
      (cru_wr && cru_idx == tipi_bus_pkg::CRU_DSR_EN) |=> (led_i == $past(bus_i.addr[15])))
      else begin
         fail_cnt++;
         $error("cru write did not reach the dsr enable bit");
      end

   // r_reset is the inverse of pi enable
   rpi_bit_write: assert property (@(posedge clk) disable iff (!arst_n_i)
      (cru_wr && cru_idx == tipi_bus_pkg::CRU_RPI_EN) |=> (r_reset_i != $past(bus_i.addr[15])))
      else begin
         fail_cnt++;
         $error("cru write did not reach the pi enable bit");
      end

endmodule

bind tipi_card tipi_card_chk u_chk (
   .clk          (clk),
   .arst_n_i     (arst_n_i),
   .enable_i     (enable_i),
   .bus_i        (bus_i),
   .wb_i         (wb_i),
   .wb_ack_i     (wb_ack_o),
   .q_select_i   (q_select_o),
   .cru_select_i (cru_select_o),
   .led_i        (led_o),
   .r_reset_i    (r_reset_o)
);

`default_nettype wire

//--- dv/tipi_card_tb.sv
`default_nettype none

`include "tipi_params.svh"

module tipi_card_tb;

   localparam int ROM_DEPTH = `TIPI_DSR_ROM_DEPTH;
   localparam int ROM_AW    = $clog2(ROM_DEPTH);
   localparam int NUM_ROM   = 32;
   localparam int ACK_WAIT  = 16;
   localparam int PI_EDGES  = 46;
   localparam int WB_XFERS  = 2 * NUM_ROM;
   localparam int LIMIT     = 2 * (PI_EDGES * 17 + WB_XFERS * (ACK_WAIT + 2) + 400);

   logic                     clk = 1'b0;
   logic                     arst_n_i;
   logic                     enable_i;
   tipi_bus_pkg::host_bus_t  bus;
   tipi_bus_pkg::wb_req_t    wb;
   tipi_link_pkg::rpi_pins_t pi;
   logic [0:7]               q_o;
   logic                     q_select_o;
   logic                     cruin_o;
   logic                     cru_select_o;
   logic                     led_o;
   logic [0:7]               wb_dat_o;
   logic                     wb_ack_o;
   logic                     r_reset_o;
   logic                     r_din_o;

   logic [31:0] lfsr;
   logic [7:0]  exp_rom [ROM_DEPTH];
   int          errs;
   int          tests_ok;
   int          tests_bad;
   int          cycles;

   tipi_card DUT (
      .clk          (clk),
      .arst_n_i     (arst_n_i),
      .enable_i     (enable_i),
      .bus_i        (bus),
      .wb_i         (wb),
      .pi_i         (pi),
      .q_o          (q_o),
      .q_select_o   (q_select_o),
      .cruin_o      (cruin_o),
      .cru_select_o (cru_select_o),
      .led_o        (led_o),
      .wb_dat_o     (wb_dat_o),
      .wb_ack_o     (wb_ack_o),
      .r_reset_o    (r_reset_o),
      .r_din_o      (r_din_o)
   );

   always #5 clk = ~clk;

   // taps 32 22 2 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_step(lfsr);
         r    = {r[30:0], lfsr[0]};
      end
      return r;
   endfunction

   task automatic check_eq(input string name, input logic [7:0] got, input logic [7:0] exp);
      assert (got === exp) else begin
         $display("FAILED %s: got %h expected %h", name, got, exp);
         errs++;
      end
   endtask

   task automatic end_test(input string name);
      if (errs == 0) begin
         $display("test %s: ok", name);
         tests_ok++;
      end else begin
         $display("test %s: %0d errors", name, errs);
         tests_bad++;
      end
      errs = 0;
   endtask

   task automatic cru_write(input logic [7:0] page, input logic [1:0] idx, input logic val);
      @(negedge clk);
      bus.addr   = {page, 5'b00000, idx, val};
      bus.cruclk = 1'b1;
      @(negedge clk);
      bus.cruclk = 1'b0;
   endtask

   task automatic cru_read(input logic [1:0] idx, output logic b);
      @(negedge clk);
      bus.addr = {`TIPI_CRU_BASE, 5'b00000, idx, 1'b0};
      @(negedge clk);
      b = cruin_o;
      check_eq("cru_select_o", cru_select_o, 1'b1);
   endtask

   task automatic verify_cru(input logic [3:0] v);
      logic b;
      for (int i = 0; i < 4; i++) begin
         cru_read(2'(i), b);
         check_eq("cruin_o", b, v[i]);
      end
      check_eq("led_o", led_o, v[0]);
      check_eq("r_reset_o", r_reset_o, !v[1]);
   endtask

   task automatic host_read(input logic [15:0] a, output logic [7:0] d);
      @(negedge clk);
      bus.addr  = a;
      bus.memen = 1'b1;
      bus.we    = 1'b0;
      @(negedge clk);   // data registered on the edge in between
      d = q_o;
      check_eq("q_select_o", q_select_o, 1'b1);
      bus.memen = 1'b0;
   endtask

   task automatic host_write(input logic [15:0] a, input logic [7:0] d);
      @(negedge clk);
      bus.addr  = a;
      bus.data  = d;
      bus.memen = 1'b1;
      bus.we    = 1'b1;
      @(negedge clk);
      bus.memen = 1'b0;
      bus.we    = 1'b0;
   endtask

   task automatic wb_xfer(input logic we, input logic [14:0] adr, input logic [7:0] dat,
                          output logic [7:0] rdat);
      int n;
      @(negedge clk);
      wb.adr = adr;
      wb.dat = dat;
      wb.we  = we;
      wb.sel = 1'b1;
      wb.cyc = 1'b1;
      wb.stb = 1'b1;
      n = 0;
      do begin
         @(negedge clk);
         n++;
      end while (!wb_ack_o && n < ACK_WAIT);
      assert (wb_ack_o) else begin
         $display("no wishbone ack for address %h", adr);
         errs++;
      end
      rdat = wb_dat_o;
      @(negedge clk);   // write lands on this edge
      wb.cyc = 1'b0;
      wb.stb = 1'b0;
      wb.we  = 1'b0;
      assert (!wb_ack_o) else begin
         $display("wishbone ack held longer than one cycle at address %h", adr);
         errs++;
      end
   endtask

   // one full pi clock period, levels held around the rising edge
   task automatic pi_edge(input logic le, input logic rt, input logic dc, input logic dout);
      @(negedge clk);
      pi.r_clk  = 1'b0;
      pi.r_le   = le;
      pi.r_rt   = rt;
      pi.r_dc   = dc;
      pi.r_dout = dout;
      repeat (8) @(negedge clk);
      pi.r_clk = 1'b1;
      repeat (8) @(negedge clk);
   endtask

   task automatic shift_in(input logic [7:0] v);
      for (int b = 0; b < 8; b++) begin
         pi_edge(1'b0, 1'b1, 1'b0, v[7-b]);   // msb first
      end
   endtask

   task automatic shift_out_check(input logic dc, input logic [7:0] v);
      pi_edge(1'b1, 1'b1, dc, 1'b0);
      for (int b = 0; b < 8; b++) begin
         pi_edge(1'b0, 1'b1, dc, 1'b0);
         check_eq("r_din_o", r_din_o, v[7-b]);
      end
   endtask

   task automatic reset_state();
      logic [7:0] d;
      bus.addr = {`TIPI_DSR_WINDOW, 13'h0000};   // window address, decoded only with dsr on
      @(negedge clk);
      check_eq("wb_ack_o", wb_ack_o, 1'b0);
      check_eq("led_o", led_o, 1'b0);
      check_eq("q_select_o", q_select_o, 1'b0);
      check_eq("r_reset_o", r_reset_o, 1'b1);
      verify_cru(4'b0000);
      cru_write(`TIPI_CRU_BASE, tipi_bus_pkg::CRU_DSR_EN, 1'b1);
      host_read({`TIPI_REG_BASE, tipi_link_pkg::MB_TD}, d);
      check_eq("q_o", d, `TIPI_TD_RESET);
      end_test("reset_state");
   endtask

   task automatic cru_control();
      logic [3:0] v;
      v = 4'(rand_bits(4));
      for (int i = 0; i < 4; i++) begin
         cru_write(`TIPI_CRU_BASE, 2'(i), v[i]);
      end
      verify_cru(v);
      for (int i = 0; i < 4; i++) begin
         cru_write(`TIPI_CRU_BASE + 8'h01, 2'(i), ~v[i]);   // wrong page
      end
      verify_cru(v);
      @(negedge clk);
      enable_i = 1'b0;
      @(negedge clk);
      check_eq("led_o", led_o, 1'b0);
      check_eq("r_reset_o", r_reset_o, 1'b1);
      check_eq("cru_select_o", cru_select_o, 1'b0);
      enable_i = 1'b1;
      verify_cru(4'b0000);
      end_test("cru_control");
   endtask

   task automatic rom_load_read();
      logic [14:0] addrs [NUM_ROM];
      logic [7:0]  d;
      logic [7:0]  r;
      logic [15:0] a;
      logic [1:0]  bank;
      int          idx;
      cru_write(`TIPI_CRU_BASE, tipi_bus_pkg::CRU_DSR_EN, 1'b1);
      for (int k = 0; k < NUM_ROM; k++) begin
         addrs[k] = 15'(rand_bits(ROM_AW));
         d = 8'(rand_bits(8));
         wb_xfer(1'b1, addrs[k], d, r);
         exp_rom[addrs[k]] = d;
      end
      for (int k = 0; k < NUM_ROM; k++) begin
         wb_xfer(1'b0, addrs[k], 8'h00, r);
         check_eq("wb_dat_o", r, exp_rom[addrs[k]]);
      end
      for (int bk = 0; bk < 4; bk++) begin
         bank = 2'(bk);
         cru_write(`TIPI_CRU_BASE, tipi_bus_pkg::CRU_BANK0, bank[0]);
         cru_write(`TIPI_CRU_BASE, tipi_bus_pkg::CRU_BANK1, bank[1]);
         for (int k = 0; k < 8; k++) begin
            a   = {`TIPI_DSR_WINDOW, addrs[k][12:0]};
            idx = int'({bank, a[12:0]}) % ROM_DEPTH;
            host_read(a, r);
            check_eq("q_o", r, exp_rom[idx]);
         end
      end
      cru_write(`TIPI_CRU_BASE, tipi_bus_pkg::CRU_BANK0, 1'b0);
      cru_write(`TIPI_CRU_BASE, tipi_bus_pkg::CRU_BANK1, 1'b0);
      end_test("rom_load_read");
   endtask

   task automatic console_to_pi();
      logic [7:0] tc;
      logic [7:0] td;
      logic [7:0] r;
      tc = 8'(rand_bits(8));
      td = 8'(rand_bits(8));
      host_write({`TIPI_REG_BASE, tipi_link_pkg::MB_TC}, tc);
      host_write({`TIPI_REG_BASE, tipi_link_pkg::MB_TD}, td);
      host_read({`TIPI_REG_BASE, tipi_link_pkg::MB_TC}, r);
      check_eq("q_o", r, tc);
      host_read({`TIPI_REG_BASE, tipi_link_pkg::MB_TD}, r);
      check_eq("q_o", r, td);
      shift_out_check(1'b1, td);
      shift_out_check(1'b0, tc);
      for (int j = 0; j < 4; j++) begin
         host_read({`TIPI_REG_BASE, 2'(j), 1'b0}, r);
         check_eq("q_o", r, 8'h00);
      end
      end_test("console_to_pi");
   endtask

   task automatic pi_to_console();
      logic [7:0] rc;
      logic [7:0] rd;
      logic [7:0] r;
      rd = 8'(rand_bits(8));
      rc = 8'(rand_bits(8));
      shift_in(rd);
      pi_edge(1'b1, 1'b0, 1'b1, 1'b0);
      shift_in(rc);
      pi_edge(1'b1, 1'b0, 1'b0, 1'b0);
      host_read({`TIPI_REG_BASE, tipi_link_pkg::MB_RD}, r);
      check_eq("q_o", r, rd);
      host_read({`TIPI_REG_BASE, tipi_link_pkg::MB_RC}, r);
      check_eq("q_o", r, rc);
      // latches with rt high must not capture
      shift_in(~rd);
      pi_edge(1'b1, 1'b1, 1'b1, 1'b0);
      pi_edge(1'b1, 1'b1, 1'b0, 1'b0);
      host_read({`TIPI_REG_BASE, tipi_link_pkg::MB_RD}, r);
      check_eq("q_o", r, rd);
      host_read({`TIPI_REG_BASE, tipi_link_pkg::MB_RC}, r);
      check_eq("q_o", r, rc);
      end_test("pi_to_console");
   endtask

   initial begin
      arst_n_i  = 1'b0;
      enable_i  = 1'b1;
      bus       = '0;
      wb        = '0;
      pi        = '0;
      lfsr      = 32'h306ae6ce;
      errs      = 0;
      tests_ok  = 0;
      tests_bad = 0;
      repeat (2) @(negedge clk);
      arst_n_i = 1'b1;
      reset_state();
      cru_control();
      rom_load_read();
      console_to_pi();
      pi_to_console();
      $display("tests ok %0d, tests failed %0d, assertion failures %0d",
               tests_ok, tests_bad, DUT.u_chk.fail_cnt);
      if (tests_bad == 0 && DUT.u_chk.fail_cnt == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

   initial begin
      cycles = 0;
      while (cycles < LIMIT) begin
         @(posedge clk);
         cycles++;
      end
      $display("run did not finish within %0d cycles", LIMIT);
      $display("Test failures found");
      $finish;
   end

endmodule

`default_nettype wire

//--- files.f
+incdir+common
common/tipi_bus_pkg.sv
common/tipi_link_pkg.sv
design/tipi_cru_bits.sv
design/tipi_host_decode.sv
dsr_rom/tipi_dsr_rom.sv
rpi_link/tipi_rpi_sync.sv
rpi_link/tipi_rpi_shifter.sv
design/tipi_card.sv
dv/tipi_card_chk.sv
dv/tipi_card_tb.sv
